// ==== hw/pg_pkg.sv ====
`default_nettype none

package pg_pkg;

    // operator register widths
    localparam int KC_W  = 7;
    localparam int KF_W  = 6;
    localparam int DT1_W = 3;
    localparam int MUL_W = 4;

    // pitch and phase datapath widths
    localparam int PITCH_W       = 13;
    localparam int PDELTA_BASE_W = 12;
    localparam int SHIFT_W       = 5;
    localparam int PDELTA_W      = 17;
    localparam int PHASE_W       = 20;
    localparam int OP_PHASE_W    = 10;

    // key code rom shape
    localparam int ROM_ADDR_W  = 6;
    localparam int ROM_MCAND_W = 4;
    localparam int ROM_INC_W   = 7;

    // highest legal pitch, key code 7E with full fraction
    localparam logic [PITCH_W-1:0] PITCH_MAX = 13'b111_1110_111111;

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        DONE
    } pg_load_state_e;

    // integer offsets 0/8/9/12, fraction offsets 0/0/52/32
    typedef enum logic [1:0] {
        DT2_NONE  = 2'd0,
        DT2_SMALL = 2'd1,
        DT2_MID   = 2'd2,
        DT2_LARGE = 2'd3
    } dt2_e;

endpackage

`default_nettype wire

// ==== hw/pg_param_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pg_param_if
    import pg_pkg::*;
();

    logic [KC_W-1:0]  kc;
    logic [KF_W-1:0]  kf;
    dt2_e             dt2;
    logic [DT1_W-1:0] dt1;
    logic [MUL_W-1:0] mul;

    // loader owns the latched values
    modport loader (output kc, kf, dt2, dt1, mul);

    // pipeline stages only read them
    modport pipe (input kc, kf, dt2, dt1, mul);

endinterface

`default_nettype wire

// ==== hw/pg_reg_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module pg_reg_loader
    import pg_pkg::*;
(
    input  logic             i_EMUCLK,
    input  logic             i_rst,
    input  logic             i_req,
    output logic             o_ack,
    input  logic [KC_W-1:0]  i_kc,
    input  logic [KF_W-1:0]  i_kf,
    input  logic [1:0]       i_dt2,
    input  logic [DT1_W-1:0] i_dt1,
    input  logic [MUL_W-1:0] i_mul,
    pg_param_if.loader       params,
    output logic             o_start,
    input  logic             i_inc_valid
);

    pg_load_state_e state_q;
    logic           capture_q;

    ////////////////////////////////////////////////////////////
    // handshake sequencer

    always_ff @(posedge i_EMUCLK) begin
        if (i_rst) begin
            state_q   <= IDLE;
            capture_q <= 1'b0;
            o_start   <= 1'b0;
            o_ack     <= 1'b0;
        end else begin
            capture_q <= 1'b0;
            // start goes out together with the captured registers
            o_start   <= capture_q;
            case (state_q)
                IDLE: begin
                    if (i_req) begin
                        capture_q <= 1'b1;
                        state_q   <= CALC;
                    end
                end
                CALC: begin
                    if (i_inc_valid) begin
                        o_ack   <= 1'b1;
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    if (!i_req) begin
                        o_ack   <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // pitch register latch

    // held until the next capture, host keeps inputs stable under req
    always_ff @(posedge i_EMUCLK) begin
        if (capture_q) begin
            params.kc  <= i_kc;
            params.kf  <= i_kf;
            params.dt2 <= dt2_e'(i_dt2);
            params.dt1 <= i_dt1;
            params.mul <= i_mul;
        end
    end

endmodule

`default_nettype wire

// ==== hw/pg_detune2.sv ====
`timescale 1ns/1ps
`default_nettype none

module pg_detune2
    import pg_pkg::*;
(
    input  logic               i_EMUCLK,
    input  logic               i_rst,
    pg_param_if.pipe           params,
    input  logic               i_start,
    output logic               o_pitch_valid,
    output logic [PITCH_W-1:0] o_pitch
);

    logic [KF_W-1:0] frac_ofs;
    logic [KC_W-1:0] int_ofs;
    logic [KF_W:0]   frac_q;
    logic            frac_valid_q;
    logic [1:0]      ng_carry;
    logic [KC_W:0]   int_sum;

    // offsets per coarse detune code
    always_comb begin
        frac_ofs = '0;
        int_ofs  = '0;
        case (params.dt2)
            DT2_SMALL: int_ofs = 7'd8;
            DT2_MID: begin
                int_ofs  = 7'd9;
                frac_ofs = 6'd52;
            end
            DT2_LARGE: begin
                int_ofs  = 7'd12;
                frac_ofs = 6'd32;
            end
            default: int_ofs = 7'd0;
        endcase
    end

    // note group carry, keeps the key code out of the x3 slots
    always_comb begin
        if (params.dt2 == DT2_MID) begin
            if (frac_q[KF_W]) begin
                ng_carry = (params.kc[1:0] == 2'b00) ? 2'd1 : 2'd2;
            end else begin
                ng_carry = {1'b0, params.kc[1]};
            end
        end else if (frac_q[KF_W]) begin
            ng_carry = params.kc[1] ? 2'd2 : 2'd1;
        end else begin
            ng_carry = 2'd0;
        end
    end

    assign int_sum = {1'b0, params.kc} + {1'b0, int_ofs} + {6'b0, ng_carry};

    always_ff @(posedge i_EMUCLK) begin
        if (i_rst) begin
            frac_valid_q  <= 1'b0;
            o_pitch_valid <= 1'b0;
        end else begin
            frac_valid_q  <= i_start;
            o_pitch_valid <= frac_valid_q;
        end
    end

    // stage 1 fraction with carry, stage 2 integer with saturation
    always_ff @(posedge i_EMUCLK) begin
        frac_q  <= {1'b0, params.kf} + {1'b0, frac_ofs};
        o_pitch <= int_sum[KC_W] ? PITCH_MAX : {int_sum[KC_W-1:0], frac_q[KF_W-1:0]};
    end

endmodule

`default_nettype wire

// ==== hw/pg_fnum_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module pg_fnum_rom
    import pg_pkg::*;
(
    input  logic                     i_EMUCLK,
    input  logic                     i_rst,
    input  logic                     i_pitch_valid,
    input  logic [PITCH_W-1:0]       i_pitch,
    output logic                     o_valid,
    output logic [SHIFT_W-1:0]       o_shift_amount,
    output logic [PDELTA_BASE_W-1:0] o_base,
    output logic [SHIFT_W-1:0]       o_eg_shift_amount
);

    logic [ROM_ADDR_W-1:0]    rom_addr;
    logic [16:0]              rom_word;
    logic [PDELTA_BASE_W-1:0] base1_q;
    logic [ROM_MCAND_W-1:0]   mcand1_q;
    logic                     calc1_q;
    logic [SHIFT_W-1:0]       shift1_q;
    logic [3:0]               mult1_q;
    logic                     valid1_q;
    logic [ROM_INC_W-1:0]     full_v;
    logic [ROM_INC_W-1:0]     odd_v;
    logic [ROM_INC_W-1:0]     inc_c;
    logic [PDELTA_BASE_W-1:0] base2_q;
    logic [ROM_INC_W-1:0]     inc2_q;
    logic                     valid2_q;

    ////////////////////////////////////////////////////////////
    // stage 1, key code table

    assign rom_addr = i_pitch[9:4];

    // word is base, then multiplicand bits 0,3,2,1 and calc mode
    always_comb begin
        case (rom_addr)
            6'h00: rom_word = {12'b010100_010011, 5'b10011};
            6'h01: rom_word = {12'b010100_100110, 5'b10011};
            6'h02: rom_word = {12'b010100_111001, 5'b10011};
            6'h03: rom_word = {12'b010101_001100, 5'b00101};
            6'h04: rom_word = {12'b010101_100000, 5'b00101};
            6'h05: rom_word = {12'b010101_110100, 5'b00101};
            6'h06: rom_word = {12'b010110_001000, 5'b10101};
            6'h07: rom_word = {12'b010110_011101, 5'b00101};
            6'h08: rom_word = {12'b010110_110010, 5'b10101};
            6'h09: rom_word = {12'b010111_000111, 5'b10101};
            6'h0A: rom_word = {12'b010111_011101, 5'b00111};
            6'h0B: rom_word = {12'b010111_110011, 5'b00111};
            6'h10: rom_word = {12'b011000_001001, 5'b00111};
            6'h11: rom_word = {12'b011000_011111, 5'b00111};
            6'h12: rom_word = {12'b011000_110110, 5'b10111};
            6'h13: rom_word = {12'b011001_001101, 5'b10111};
            6'h14: rom_word = {12'b011001_100101, 5'b10111};
            6'h15: rom_word = {12'b011001_111100, 5'b01001};
            6'h16: rom_word = {12'b011010_010101, 5'b01001};
            6'h17: rom_word = {12'b011010_101101, 5'b01001};
            6'h18: rom_word = {12'b011011_000110, 5'b11001};
            6'h19: rom_word = {12'b011011_011111, 5'b11001};
            6'h1A: rom_word = {12'b011011_111001, 5'b01011};
            6'h1B: rom_word = {12'b011100_010011, 5'b01011};
            6'h20: rom_word = {12'b011100_101101, 5'b01011};
            6'h21: rom_word = {12'b011101_001000, 5'b11011};
            6'h22: rom_word = {12'b011101_100011, 5'b11011};
            6'h23: rom_word = {12'b011101_111110, 5'b01101};
            6'h24: rom_word = {12'b011110_011010, 5'b01101};
            6'h25: rom_word = {12'b011110_110111, 5'b01101};
            6'h26: rom_word = {12'b011111_010011, 5'b11101};
            6'h27: rom_word = {12'b011111_110000, 5'b01111};
            6'h28: rom_word = {12'b100000_001110, 5'b01111};
            6'h29: rom_word = {12'b100000_101100, 5'b01111};
            6'h2A: rom_word = {12'b100001_001010, 5'b11111};
            6'h2B: rom_word = {12'b100001_101001, 5'b11111};
            6'h30: rom_word = {12'b100010_001001, 5'b11111};
            6'h31: rom_word = {12'b100010_101000, 5'b11110};
            6'h32: rom_word = {12'b100011_001001, 5'b11110};
            6'h33: rom_word = {12'b100011_101001, 5'b11110};
            6'h34: rom_word = {12'b100100_001011, 5'b11110};
            6'h35: rom_word = {12'b100100_101100, 5'b11110};
            6'h36: rom_word = {12'b100101_001110, 5'b01110};
            6'h37: rom_word = {12'b100101_110001, 5'b01110};
            6'h38: rom_word = {12'b100110_010100, 5'b01110};
            6'h39: rom_word = {12'b100110_111000, 5'b01110};
            6'h3A: rom_word = {12'b100111_011100, 5'b01110};
            6'h3B: rom_word = {12'b101000_000001, 5'b01110};
            // note codes x3, x7, xB and xF
            default: rom_word = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // stage 2, interpolation increment

    assign full_v = {3'b001, mcand1_q};
    assign odd_v  = {3'b001, mcand1_q[3:1], 1'b1};

    always_comb begin
        if (calc1_q) begin
            inc_c = (full_v & {7{mult1_q[3]}}) + ((full_v >> 1) & {7{mult1_q[2]}})
                  + ((full_v >> 2) & {7{mult1_q[1]}}) + ((full_v >> 3) & {7{mult1_q[0]}});
        end else begin
            inc_c = (odd_v & {7{mult1_q[3]}}) + ((odd_v >> 1) & {7{mult1_q[2]}})
                  + ((odd_v >> 3) & {7{mult1_q[0]}})
                  + ((mult1_q[3] & mult1_q[2] & ~mcand1_q[0]) ? 7'd4 : 7'd0)
                  + (mult1_q[3] ? 7'd1 : 7'd0)
                  + (mult1_q[1] ? 7'd8 : 7'd0)
                  + (mult1_q[0] ? 7'd2 : 7'd0);
        end
    end

    ////////////////////////////////////////////////////////////
    // stage registers

    always_ff @(posedge i_EMUCLK) begin
        if (i_rst) begin
            valid1_q          <= 1'b0;
            valid2_q          <= 1'b0;
            o_valid           <= 1'b0;
            o_eg_shift_amount <= '0;
        end else begin
            valid1_q          <= i_pitch_valid;
            valid2_q          <= valid1_q;
            o_valid           <= valid2_q;
            o_eg_shift_amount <= shift1_q;
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        base1_q        <= rom_word[16:5];
        mcand1_q       <= {rom_word[3:1], rom_word[4]};
        calc1_q        <= rom_word[0];
        shift1_q       <= i_pitch[12:8];
        mult1_q        <= i_pitch[3:0];
        base2_q        <= base1_q;
        inc2_q         <= inc_c;
        // increment lsb is dropped
        o_base         <= base2_q + {6'b0, inc2_q[ROM_INC_W-1:1]};
        o_shift_amount <= o_eg_shift_amount;
    end

endmodule

`default_nettype wire

// ==== hw/pg_dt1_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module pg_dt1_mul
    import pg_pkg::*;
(
    input  logic                     i_EMUCLK,
    input  logic                     i_rst,
    pg_param_if.pipe                 params,
    input  logic                     i_valid,
    input  logic [SHIFT_W-1:0]       i_shift_amount,
    input  logic [PDELTA_BASE_W-1:0] i_base,
    output logic                     o_inc_valid,
    output logic [PHASE_W-1:0]       o_inc
);

    logic [18:0]         shift_wide;
    logic [4:0]          dt1_int;
    logic [1:0]          pla_sel;
    logic [4:0]          pla_base;
    logic [PDELTA_W-1:0] dt1_mag;
    logic [PDELTA_W-1:0] dt1_c;
    logic [PDELTA_W-1:0] shifted_q;
    logic [PDELTA_W-1:0] dt1_q;
    logic [PDELTA_W-1:0] detuned_q;
    logic [PHASE_W:0]    mul_q;
    logic                valid1_q;
    logic                valid2_q;
    logic                valid3_q;

    ////////////////////////////////////////////////////////////
    // stage 1, octave shift and dt1 decode

    // octave 0 is base >> 2, octave 7 is base << 5
    assign shift_wide = {7'b0, i_base} << i_shift_amount[4:2];

    always_comb begin
        case (params.dt1[1:0])
            2'd0:    dt1_int = {2'b0, i_shift_amount[4:2]} + 5'd1;
            2'd1:    dt1_int = {2'b0, i_shift_amount[4:2]} + 5'd9;
            2'd2:    dt1_int = {2'b0, i_shift_amount[4:2]} + 5'd11;
            default: dt1_int = {2'b0, i_shift_amount[4:2]} + 5'd12;
        endcase
    end

    // top key codes share the first pla column
    assign pla_sel = (i_shift_amount >= 5'd28) ? 2'd0 : i_shift_amount[1:0];

    always_comb begin
        case ({dt1_int[0], pla_sel})
            3'b0_00: pla_base = 5'b10000;
            3'b0_01: pla_base = 5'b10001;
            3'b0_10: pla_base = 5'b10011;
            3'b0_11: pla_base = 5'b10100;
            3'b1_00: pla_base = 5'b10110;
            3'b1_01: pla_base = 5'b11000;
            3'b1_10: pla_base = 5'b11011;
            default: pla_base = 5'b11101;
        endcase
    end

    // more pla bits kept as intensity rises from 10 to 19
    always_comb begin
        case (dt1_int[4:1])
            4'd5:    dt1_mag = {16'b0, pla_base[4]};
            4'd6:    dt1_mag = {15'b0, pla_base[4:3]};
            4'd7:    dt1_mag = {14'b0, pla_base[4:2]};
            4'd8:    dt1_mag = {13'b0, pla_base[4:1]};
            4'd9:    dt1_mag = {12'b0, pla_base};
            default: dt1_mag = '0;
        endcase
        if (params.dt1 == '0) begin
            dt1_c = '0;
        end else if (params.dt1[2]) begin
            dt1_c = ~dt1_mag + 17'd1;
        end else begin
            dt1_c = dt1_mag;
        end
    end

    ////////////////////////////////////////////////////////////
    // stages 2 to 4, detune add, multiply, truncate

    always_ff @(posedge i_EMUCLK) begin
        if (i_rst) begin
            valid1_q    <= 1'b0;
            valid2_q    <= 1'b0;
            valid3_q    <= 1'b0;
            o_inc_valid <= 1'b0;
        end else begin
            valid1_q    <= i_valid;
            valid2_q    <= valid1_q;
            valid3_q    <= valid2_q;
            o_inc_valid <= valid3_q;
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        shifted_q <= shift_wide[18:2];
        dt1_q     <= dt1_c;
        detuned_q <= shifted_q + dt1_q;
        // mul 0 means one half
        mul_q     <= (params.mul == '0) ? {5'b0, detuned_q[PDELTA_W-1:1]}
                                        : detuned_q * params.mul;
        o_inc     <= mul_q[PHASE_W-1:0];
    end

endmodule

`default_nettype wire

// ==== hw/pg_phase_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

module pg_phase_acc
    import pg_pkg::*;
(
    input  logic                  i_EMUCLK,
    input  logic                  i_rst,
    input  logic                  i_inc_valid,
    input  logic [PHASE_W-1:0]    i_inc,
    input  logic                  i_phase_rst,
    output logic [OP_PHASE_W-1:0] o_op_phase
);

    logic [PHASE_W-1:0] inc_q;
    logic [PHASE_W-1:0] phase_q;

    // new increment takes effect one clock after it lands
    always_ff @(posedge i_EMUCLK) begin
        if (i_rst) begin
            inc_q   <= '0;
            phase_q <= '0;
        end else begin
            if (i_inc_valid) begin
                inc_q <= i_inc;
            end
            if (i_phase_rst) begin
                phase_q <= '0;
            end else begin
                phase_q <= phase_q + inc_q;
            end
        end
    end

    assign o_op_phase = phase_q[PHASE_W-1:PHASE_W-OP_PHASE_W];

endmodule

`default_nettype wire

// ==== hw/pg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pg_top
    import pg_pkg::*;
(
    input  logic                  i_EMUCLK,
    input  logic                  i_rst,
    input  logic                  i_req,
    output logic                  o_ack,
    input  logic [KC_W-1:0]       i_kc,
    input  logic [KF_W-1:0]       i_kf,
    input  logic [1:0]            i_dt2,
    input  logic [DT1_W-1:0]      i_dt1,
    input  logic [MUL_W-1:0]      i_mul,
    input  logic                  i_phase_rst,
    output logic [OP_PHASE_W-1:0] o_op_phase,
    output logic [SHIFT_W-1:0]    o_eg_shift_amount
);

    logic                     start;
    logic                     pitch_valid;
    logic [PITCH_W-1:0]       pitch;
    logic                     rom_valid;
    logic [SHIFT_W-1:0]       rom_shift_amount;
    logic [PDELTA_BASE_W-1:0] rom_base;
    logic                     inc_valid;
    logic [PHASE_W-1:0]       inc;

    pg_param_if u_params ();

    pg_reg_loader u_loader (
        .i_EMUCLK    (i_EMUCLK),
        .i_rst       (i_rst),
        .i_req       (i_req),
        .o_ack       (o_ack),
        .i_kc        (i_kc),
        .i_kf        (i_kf),
        .i_dt2       (i_dt2),
        .i_dt1       (i_dt1),
        .i_mul       (i_mul),
        .params      (u_params.loader),
        .o_start     (start),
        .i_inc_valid (inc_valid)
    );

    pg_detune2 u_detune2 (
        .i_EMUCLK      (i_EMUCLK),
        .i_rst         (i_rst),
        .params        (u_params.pipe),
        .i_start       (start),
        .o_pitch_valid (pitch_valid),
        .o_pitch       (pitch)
    );

    pg_fnum_rom u_fnum_rom (
        .i_EMUCLK          (i_EMUCLK),
        .i_rst             (i_rst),
        .i_pitch_valid     (pitch_valid),
        .i_pitch           (pitch),
        .o_valid           (rom_valid),
        .o_shift_amount    (rom_shift_amount),
        .o_base            (rom_base),
        .o_eg_shift_amount (o_eg_shift_amount)
    );

    pg_dt1_mul u_dt1_mul (
        .i_EMUCLK       (i_EMUCLK),
        .i_rst          (i_rst),
        .params         (u_params.pipe),
        .i_valid        (rom_valid),
        .i_shift_amount (rom_shift_amount),
        .i_base         (rom_base),
        .o_inc_valid    (inc_valid),
        .o_inc          (inc)
    );

    pg_phase_acc u_phase_acc (
        .i_EMUCLK    (i_EMUCLK),
        .i_rst       (i_rst),
        .i_inc_valid (inc_valid),
        .i_inc       (inc),
        .i_phase_rst (i_phase_rst),
        .o_op_phase  (o_op_phase)
    );

endmodule

`default_nettype wire

// ==== verification/pg_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module pg_assertions
    import pg_pkg::*;
(
    input logic                  i_EMUCLK,
    input logic                  i_rst,
    input logic                  i_req,
    input logic                  i_ack,
    input logic                  i_phase_rst,
    input logic [OP_PHASE_W-1:0] i_op_phase
);

    int n_fail = 0;

    // ack only answers a pending request
    ack_rise_with_req: assert property (@(posedge i_EMUCLK) disable iff (i_rst)
        $rose(i_ack) |-> i_req)
        else begin
            $error("ack rose while req was low");
            n_fail++;
        end

    // release needs req seen low first
    ack_fall_after_req: assert property (@(posedge i_EMUCLK) disable iff (i_rst)
        $fell(i_ack) |-> !$past(i_req))
        else begin
            $error("ack fell while req was still high");
            n_fail++;
        end

    // phase reset clears the operator phase
    phase_rst_clears: assert property (@(posedge i_EMUCLK) disable iff (i_rst)
        i_phase_rst |=> (i_op_phase == '0))
        else begin
            $error("op phase not zero after phase reset");
            n_fail++;
        end

endmodule

bind pg_top pg_assertions u_pg_assertions (
    .i_EMUCLK    (i_EMUCLK),
    .i_rst       (i_rst),
    .i_req       (i_req),
    .i_ack       (o_ack),
    .i_phase_rst (i_phase_rst),
    .i_op_phase  (o_op_phase)
);

`default_nettype wire

// ==== verification/pg_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pg_tb;

    localparam int ACK_TIMEOUT = 100;

    logic       emu_clk;
    logic       rst;
    logic       req;
    logic       ack;
    logic [6:0] kc;
    logic [5:0] kf;
    logic [1:0] dt2;
    logic [2:0] dt1;
    logic [3:0] mul;
    logic       phase_rst;
    logic [9:0] op_phase;
    logic [4:0] eg_shift;
    logic [31:0] rng_state;

    pg_top u_pg_top (
        .i_EMUCLK          (emu_clk),
        .i_rst             (rst),
        .i_req             (req),
        .o_ack             (ack),
        .i_kc              (kc),
        .i_kf              (kf),
        .i_dt2             (dt2),
        .i_dt1             (dt1),
        .i_mul             (mul),
        .i_phase_rst       (phase_rst),
        .o_op_phase        (op_phase),
        .o_eg_shift_amount (eg_shift)
    );

    initial begin
        emu_clk = 1'b0;
        forever #10 emu_clk = ~emu_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int next_rand();
        rng_state = xorshift32(rng_state);
        return int'(rng_state & 32'h7fffffff);
    endfunction

    ////////////////////////////////////////////////////////////
    // failure reporting

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic value_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    // bound checker failures end the run
    always @(negedge emu_clk) begin
        if (u_pg_top.u_pg_assertions.n_fail != 0) begin
            abort_run("a bound assertion on the handshake or phase reset failed");
        end
    end

    ////////////////////////////////////////////////////////////
    // handshake and phase checks

    task automatic load_vector(input logic [31:0] v_kc, input logic [31:0] v_kf,
                               input logic [31:0] v_dt2, input logic [31:0] v_dt1,
                               input logic [31:0] v_mul, input logic [4:0] exp_shift);
        int cycles;
        @(posedge emu_clk);
        kc  <= v_kc[6:0];
        kf  <= v_kf[5:0];
        dt2 <= v_dt2[1:0];
        dt1 <= v_dt1[2:0];
        mul <= v_mul[3:0];
        req <= 1'b1;
        cycles = 0;
        do begin
            @(negedge emu_clk);
            cycles++;
        end while (!ack && cycles < ACK_TIMEOUT);
        if (!ack) begin
            abort_run("timeout while waiting for ack to rise");
        end
        assert (eg_shift == exp_shift)
            else value_mismatch($sformatf("shift amount %h, expected %h", eg_shift, exp_shift));
        // ack must hold while req is still high
        @(negedge emu_clk);
        assert (ack == 1'b1)
            else value_mismatch("ack dropped while req was high");
        @(posedge emu_clk);
        req <= 1'b0;
        cycles = 0;
        do begin
            @(negedge emu_clk);
            cycles++;
        end while (ack && cycles < ACK_TIMEOUT);
        if (ack) begin
            abort_run("timeout while waiting for ack to fall");
        end
    endtask

    task automatic check_phase_after(input int k, input logic [19:0] exp_inc);
        logic [63:0] prod;
        logic [9:0]  exp_phase;
        prod      = 64'(k) * 64'(exp_inc);
        exp_phase = prod[19:10];
        @(posedge emu_clk);
        phase_rst <= 1'b1;
        @(posedge emu_clk);
        phase_rst <= 1'b0;
        repeat (k) @(posedge emu_clk);
        @(negedge emu_clk);
        assert (op_phase == exp_phase)
            else value_mismatch($sformatf("op phase %h after %0d clocks, expected %h",
                                          op_phase, k, exp_phase));
    endtask

    task automatic hold_phase_rst(input int n);
        @(posedge emu_clk);
        phase_rst <= 1'b1;
        @(posedge emu_clk);
        for (int i = 0; i < n; i++) begin
            @(negedge emu_clk);
            assert (op_phase == '0)
                else value_mismatch($sformatf("op phase %h under held reset", op_phase));
        end
        @(posedge emu_clk);
        phase_rst <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        int          fd;
        int          code;
        int          n_vec;
        int          k;
        int          gap;
        string       line;
        logic [31:0] f_kc;
        logic [31:0] f_kf;
        logic [31:0] f_dt2;
        logic [31:0] f_dt1;
        logic [31:0] f_mul;
        logic [31:0] f_inc;
        logic [31:0] f_shift;

        rng_state = 32'hec2313e6;
        n_vec     = 0;
        rst       <= 1'b1;
        req       <= 1'b0;
        kc        <= '0;
        kf        <= '0;
        dt2       <= '0;
        dt1       <= '0;
        mul       <= '0;
        phase_rst <= 1'b0;
        repeat (4) @(posedge emu_clk);
        rst <= 1'b0;

        @(negedge emu_clk);
        assert (ack == 1'b0 && op_phase == '0 && eg_shift == '0)
            else value_mismatch("outputs not cleared after reset");

        fd = $fopen("verification/pg_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the vector file");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 0 && line[0] != "#") begin
                code = $sscanf(line, "%h %h %h %h %h %h %h",
                               f_kc, f_kf, f_dt2, f_dt1, f_mul, f_inc, f_shift);
                if (code == 7) begin
                    gap = next_rand() % 8;
                    repeat (gap) @(posedge emu_clk);
                    load_vector(f_kc, f_kf, f_dt2, f_dt1, f_mul, f_shift[4:0]);
                    k = 1 + (next_rand() % 2000);
                    // big increments get a long run so the phase wraps
                    if (f_inc[19:0] >= 20'h20000) begin
                        k = 1000 + (next_rand() % 1001);
                    end
                    check_phase_after(k, f_inc[19:0]);
                    hold_phase_rst(5);
                    n_vec++;
                end
            end
        end
        $fclose(fd);

        // let the last edge's concurrent checks settle
        @(negedge emu_clk);
        if (n_vec > 0 && u_pg_top.u_pg_assertions.n_fail == 0) begin
            $display("all tests passed");
            $finish;
        end else if (n_vec == 0) begin
            abort_run("no vectors were read");
        end else begin
            abort_run("a bound assertion on the handshake or phase reset failed");
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
hw/pg_pkg.sv
hw/pg_param_if.sv
hw/pg_reg_loader.sv
hw/pg_detune2.sv
hw/pg_fnum_rom.sv
hw/pg_dt1_mul.sv
hw/pg_phase_acc.sv
hw/pg_top.sv
verification/pg_assertions.sv
verification/pg_tb.sv

// ==== verification/pg_testdata.txt ====
# columns in hex: kc kf dt2 dt1 mul expected_increment expected_shift
# plain reference, dt1 +/-, mul 0 and 2, each dt2 code, x3 key code, saturation, wrap
40 00 0 0 1 0144c 10
40 00 0 3 1 01454 10
40 00 0 7 2 02888 10
40 00 0 0 0 00a26 10
21 10 1 0 3 01725 0a
12 0c 2 0 1 00485 07
33 00 0 1 5 0000a 0c
7e 30 3 0 1 14420 1f
7e 3f 0 2 f 2fed0 1f
